/* design/scaler_defs.svh */
// ----------------------------------------------------------
// width and depth macros of the nearest-neighbour scaler
// included by the package and by every module that sizes
// its ports or counters from them
// ----------------------------------------------------------
`ifndef SCALER_DEFS_SVH
`define SCALER_DEFS_SVH

`define SCL_PIX_W        8     // per colour channel
`define SCL_DIM_W        11    // image sizes and row counts
`define SCL_COL_W        10
`define SCL_SLOT_W       2     // four row slots per bank
`define SCL_LB_ADDR_W    12
`define SCL_RATIO_W      16    // fraction bits of the step ratio
`define SCL_ACC_W        27
`define SCL_TAG_DEPTH_W  4
`define SCL_PIPE_LAT     7     // column issue to output

`endif

/* design/scaler_pkg.sv */
// ----------------------------------------------------------
// shared packed types of the scaler
// modules name these by scope in their ports and import the
// package in their bodies
// ----------------------------------------------------------
`default_nettype none
`include "scaler_defs.svh"

package scaler_pkg;

    typedef struct packed {
        logic [`SCL_PIX_W-1:0] r;
        logic [`SCL_PIX_W-1:0] g;
        logic [`SCL_PIX_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic vsync;
        logic de;
        rgb_t pix;
    } video_t;

    typedef struct packed {
        logic [`SCL_DIM_W-1:0]   src_width;
        logic [`SCL_DIM_W-1:0]   src_height;
        logic [`SCL_DIM_W-1:0]   dst_width;
        logic [`SCL_DIM_W-1:0]   dst_height;
        logic [`SCL_RATIO_W-1:0] x_ratio;     // 2^16 is 1.0
        logic [`SCL_RATIO_W-1:0] y_ratio;
    } scaler_cfg_t;

    // ------------------------------------------------------
    // line buffer addressing
    // ------------------------------------------------------
    typedef struct packed {
        logic [`SCL_SLOT_W-1:0] slot;
        logic [`SCL_COL_W-1:0]  col;
    } lb_slot_col_t;

    typedef union packed {
        logic [`SCL_LB_ADDR_W-1:0] raw;
        lb_slot_col_t              f;
    } lb_addr_u;

    typedef struct packed {
        logic     wen_even;
        logic     wen_odd;
        lb_addr_u addr;
        rgb_t     data;
    } lb_wr_t;

    typedef struct packed {
        lb_addr_u addr_lo;   // left column
        lb_addr_u addr_hi;
    } lb_bank_rd_t;

    typedef struct packed {
        lb_bank_rd_t even;
        lb_bank_rd_t odd;
    } lb_rd_t;

    // p<row><col> of the 2x2 neighbourhood
    typedef struct packed {
        rgb_t p00;
        rgb_t p01;
        rgb_t p10;
        rgb_t p11;
    } quad_t;

    typedef struct packed {
        logic [`SCL_DIM_W-1:0] x_int;
        logic [`SCL_DIM_W-1:0] y_int;
        logic                  x_half;
        logic                  y_half;
        logic                  issue;
        logic                  frame_start;
    } coord_t;

endpackage

`default_nettype wire

/* design/row_writer.sv */
// ----------------------------------------------------------
// source side of the scaler
// counts rows and columns of the input stream, writes each
// pixel into the line buffer and pushes a tag per full row
// ----------------------------------------------------------
`default_nettype none
`include "scaler_defs.svh"

module row_writer (
    input  logic                  clk_in2,
    input  logic                  rst_n,
    input  scaler_pkg::video_t    in_video,
    input  logic [`SCL_DIM_W-1:0] src_width,
    output scaler_pkg::lb_wr_t    wr,
    output logic                  tag_push,
    output logic [`SCL_DIM_W-1:0] tag_row
);

    logic                  de_q;
    logic [`SCL_DIM_W-1:0] row_cnt;    // source row being received
    logic [`SCL_DIM_W-1:0] col_cnt;
    logic                  take;
    logic                  de_fall;

    assign take    = in_video.vsync & in_video.de;
    assign de_fall = de_q & ~in_video.de;

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            de_q    <= 1'b0;
            row_cnt <= '0;
            col_cnt <= '0;
        end
        else
        begin
            de_q <= in_video.de;
            if (!in_video.vsync)
                row_cnt <= '0;
            else if (de_fall)
                row_cnt <= row_cnt + 1'b1;   // row done
            if (take)
                col_cnt <= col_cnt + 1'b1;
            else
                col_cnt <= '0;
        end
    end

    // even rows to the even bank, slot from row bits 2:1
    always_ff @(posedge clk_in2)
    begin
        wr.data        <= in_video.pix;
        wr.addr.f.slot <= row_cnt[2:1];
        wr.addr.f.col  <= col_cnt[`SCL_COL_W-1:0];
        tag_row        <= row_cnt;
        if (!rst_n)
        begin
            wr.wen_even <= 1'b0;
            wr.wen_odd  <= 1'b0;
            tag_push    <= 1'b0;
        end
        else
        begin
            wr.wen_even <= take & ~row_cnt[0];
            wr.wen_odd  <= take & row_cnt[0];
            tag_push    <= take && (col_cnt == src_width - 1'b1);
        end
    end

endmodule

`default_nettype wire

/* design/row_tag_fifo.sv */
// ----------------------------------------------------------
// queue of completed source row indices
// written by the row writer, read by the sequencer; the head
// is visible while not empty and a pop acts on the next edge
// ----------------------------------------------------------
`default_nettype none
`include "scaler_defs.svh"

module row_tag_fifo (
    input  logic                  clk_in2,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic [`SCL_DIM_W-1:0] push_row,
    input  logic                  pop,
    output logic [`SCL_DIM_W-1:0] head_row,
    output logic                  empty
);

    localparam int AW    = `SCL_TAG_DEPTH_W;
    localparam int DEPTH = 1 << AW;

    logic [`SCL_DIM_W-1:0] mem [DEPTH];
    logic [AW:0]           wr_ptr;     // extra msb tells full from empty
    logic [AW:0]           rd_ptr;
    logic                  full;

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign head_row = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk_in2)
    begin
        if (push && !full)
            mem[wr_ptr[AW-1:0]] <= push_row;
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // source ran too far ahead of the sequencer
    a_no_overflow: assert property (@(posedge clk_in2) disable iff (!rst_n)
        push |-> !full);

    a_no_underflow: assert property (@(posedge clk_in2) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

/* design/line_buffer.sv */
// ----------------------------------------------------------
// line buffer of eight source rows in an even and an odd bank
// one write port and two read ports per bank; read data
// comes two cycles after the address
// ----------------------------------------------------------
`default_nettype none
`include "scaler_defs.svh"

module line_buffer (
    input  logic               clk_in2,
    input  scaler_pkg::lb_wr_t wr,
    input  scaler_pkg::lb_rd_t rd,
    output scaler_pkg::quad_t  quad
);

    import scaler_pkg::*;

    localparam int DEPTH = 1 << `SCL_LB_ADDR_W;

    // bank 0 holds even rows, bank 1 odd rows
    for (genvar b = 0; b < 2; b++)
    begin : g_bank
        rgb_t        mem [DEPTH];
        rgb_t        lo_rd;
        rgb_t        hi_rd;
        rgb_t        lo_q;
        rgb_t        hi_q;
        logic        wen;
        lb_bank_rd_t addr;

        assign wen  = (b == 0) ? wr.wen_even : wr.wen_odd;
        assign addr = (b == 0) ? rd.even : rd.odd;

        always_ff @(posedge clk_in2)
        begin
            if (wen)
                mem[wr.addr.raw] <= wr.data;
            lo_rd <= mem[addr.addr_lo.raw];
            hi_rd <= mem[addr.addr_hi.raw];
            lo_q  <= lo_rd;    // output register
            hi_q  <= hi_rd;
        end
    end

    assign quad.p00 = g_bank[0].lo_q;
    assign quad.p01 = g_bank[0].hi_q;
    assign quad.p10 = g_bank[1].lo_q;
    assign quad.p11 = g_bank[1].hi_q;

endmodule

`default_nettype wire

/* design/scale_sequencer.sv */
// ----------------------------------------------------------
// destination grid walker
// waits for source row tags, then issues one destination
// column per cycle with fixed-point source coordinates
// ----------------------------------------------------------
`default_nettype none
`include "scaler_defs.svh"

module scale_sequencer (
    input  logic                    clk_in2,
    input  logic                    rst_n,
    input  scaler_pkg::scaler_cfg_t cfg,
    input  logic                    tag_empty,
    input  logic [`SCL_DIM_W-1:0]   tag_row,
    output logic                    tag_pop,
    output scaler_pkg::coord_t      coord
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_ROW_LOAD  = 3'd1;
    localparam logic [2:0] S_COL_ISSUE = 3'd2;
    localparam logic [2:0] S_ROW_INC   = 3'd3;
    localparam logic [2:0] S_TAG_POP   = 3'd4;

    logic [2:0]            state;
    logic [`SCL_ACC_W-1:0] x_acc;
    logic [`SCL_ACC_W-1:0] y_acc;
    logic [`SCL_DIM_W-1:0] x_cnt;
    logic [`SCL_DIM_W-1:0] y_cnt;      // destination row
    logic [`SCL_DIM_W-1:0] y_int;
    logic                  new_frame;
    logic                  row_ready;
    logic                  last_col;
    logic                  last_row;

    assign y_int     = y_acc[`SCL_ACC_W-1:`SCL_RATIO_W];
    assign new_frame = (state == S_IDLE) && !tag_empty && (tag_row == '0);
    // both neighbour rows written, or the whole source frame is in
    assign row_ready = ({1'b0, y_int} + 1'b1 <= {1'b0, tag_row})
                    || (tag_row == cfg.src_height - 1'b1);
    assign last_col  = (x_cnt == cfg.dst_width - 1'b1);
    assign last_row  = (y_cnt == cfg.dst_height - 1'b1);
    assign tag_pop   = (state == S_TAG_POP);

    // ------------------------------------------------------
    // FSM
    // ------------------------------------------------------
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (!tag_empty)
                    begin
                        if (tag_row != '0 && y_cnt == cfg.dst_height)
                            state <= S_TAG_POP;   // leftover rows of a done frame
                        else
                            state <= S_ROW_LOAD;
                    end
                end
                S_ROW_LOAD:
                    state <= row_ready ? S_COL_ISSUE : S_TAG_POP;
                S_COL_ISSUE:
                begin
                    if (last_col)
                        state <= S_ROW_INC;
                end
                S_ROW_INC:
                    state <= last_row ? S_TAG_POP : S_ROW_LOAD;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            y_acc <= '0;
            y_cnt <= '0;
        end
        else if (new_frame)
        begin
            y_acc <= '0;
            y_cnt <= '0;
        end
        else if (state == S_ROW_INC)
        begin
            y_acc <= y_acc + cfg.y_ratio;
            y_cnt <= y_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n || state != S_COL_ISSUE)
        begin
            x_acc <= '0;
            x_cnt <= '0;
        end
        else
        begin
            x_acc <= x_acc + cfg.x_ratio;
            x_cnt <= x_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_in2)
    begin
        coord.x_int  <= x_acc[`SCL_ACC_W-1:`SCL_RATIO_W];
        coord.y_int  <= y_int;
        coord.x_half <= x_acc[`SCL_RATIO_W-1];   // rounding bits
        coord.y_half <= y_acc[`SCL_RATIO_W-1];
        if (!rst_n)
        begin
            coord.issue       <= 1'b0;
            coord.frame_start <= 1'b0;
        end
        else
        begin
            coord.issue       <= (state == S_COL_ISSUE);
            coord.frame_start <= (state == S_COL_ISSUE) && (x_cnt == '0) && (y_cnt == '0);
        end
    end

    // a destination row only starts with a source tag at the head
    a_issue_needs_tag: assert property (@(posedge clk_in2) disable iff (!rst_n)
        $rose(coord.issue) |-> !$past(tag_empty, 2));

endmodule

`default_nettype wire

/* design/sample_pipe.sv */
// ----------------------------------------------------------
// sampling pipeline from source coordinates to output pixels
// forms line buffer reads, swaps banks for odd rows, clamps
// at the right and bottom edges and picks the nearest pixel
// ----------------------------------------------------------
`default_nettype none
`include "scaler_defs.svh"

module sample_pipe (
    input  logic                    clk_in2,
    input  logic                    rst_n,
    input  scaler_pkg::scaler_cfg_t cfg,
    input  scaler_pkg::coord_t      coord,
    output scaler_pkg::lb_rd_t      rd,
    input  scaler_pkg::quad_t       quad,
    output scaler_pkg::video_t      out_video
);

    import scaler_pkg::*;

    // coord is stage 1, stage LAST feeds the output register
    localparam int LAST = `SCL_PIPE_LAT - 1;

    typedef struct packed {
        logic odd_row;     // top neighbour sits in the odd bank
        logic right;
        logic bottom;
        logic x_half;
        logic y_half;
    } side_t;

    side_t                 side_q [2:LAST];
    logic [LAST:2]         de_q;
    logic [LAST:2]         vs_q;
    logic [`SCL_DIM_W-1:0] row_cnt;    // destination rows done this frame
    logic                  row_end;
    lb_addr_u              addr_c2;
    lb_addr_u              lo_cur;
    lb_addr_u              hi_cur;
    lb_addr_u              lo_nxt;
    lb_addr_u              hi_nxt;
    quad_t                 nbr;
    quad_t                 nbr_q;

    assign row_end = de_q[2] & ~coord.issue;

    // ------------------------------------------------------
    // sync delay, vsync spans the destination frame
    // ------------------------------------------------------
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            de_q    <= '0;
            vs_q    <= '0;
            row_cnt <= '0;
        end
        else
        begin
            de_q         <= {de_q[LAST-1:2], coord.issue};
            vs_q[LAST:3] <= vs_q[LAST-1:2];
            if (coord.issue && coord.frame_start)
            begin
                vs_q[2] <= 1'b1;
                row_cnt <= '0;
            end
            else if (row_end)
            begin
                if (row_cnt == cfg.dst_height - 1'b1)
                    vs_q[2] <= 1'b0;
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in2)
    begin
        addr_c2.f.slot   <= coord.y_int[2:1];
        addr_c2.f.col    <= coord.x_int[`SCL_COL_W-1:0];
        side_q[2].odd_row <= coord.y_int[0];
        side_q[2].right  <= (coord.x_int == cfg.src_width - 1'b1);
        side_q[2].bottom <= (coord.y_int == cfg.src_height - 1'b1);
        side_q[2].x_half <= coord.x_half;
        side_q[2].y_half <= coord.y_half;
        for (int n = 3; n <= LAST; n++)
            side_q[n] <= side_q[n-1];
    end

    // ------------------------------------------------------
    // stage 3, bank addresses
    // ------------------------------------------------------
    always_comb
    begin
        lo_cur        = addr_c2;
        hi_cur        = addr_c2;
        hi_cur.f.col  = addr_c2.f.col + 1'b1;
        lo_nxt        = lo_cur;
        lo_nxt.f.slot = addr_c2.f.slot + 1'b1;
        hi_nxt        = hi_cur;
        hi_nxt.f.slot = addr_c2.f.slot + 1'b1;
    end

    // an odd row pairs with the even row one slot further on
    always_ff @(posedge clk_in2)
    begin
        rd.odd.addr_lo  <= lo_cur;
        rd.odd.addr_hi  <= hi_cur;
        rd.even.addr_lo <= side_q[2].odd_row ? lo_nxt : lo_cur;
        rd.even.addr_hi <= side_q[2].odd_row ? hi_nxt : hi_cur;
    end

    // ------------------------------------------------------
    // bank swap and edge clamp on the buffer read data
    // ------------------------------------------------------
    always_comb
    begin
        if (side_q[LAST-1].odd_row)
            nbr = '{p00: quad.p10, p01: quad.p11, p10: quad.p00, p11: quad.p01};
        else
            nbr = quad;
        if (side_q[LAST-1].right)
        begin
            nbr.p01 = nbr.p00;
            nbr.p11 = nbr.p10;
        end
        if (side_q[LAST-1].bottom)
        begin
            nbr.p10 = nbr.p00;
            nbr.p11 = nbr.p01;
        end
    end

    always_ff @(posedge clk_in2)
    begin
        nbr_q <= nbr;
    end

    // nearest of the four by the rounding bits
    always_ff @(posedge clk_in2)
    begin
        case ({side_q[LAST].x_half, side_q[LAST].y_half})
            2'b00:   out_video.pix <= nbr_q.p00;
            2'b01:   out_video.pix <= nbr_q.p10;
            2'b10:   out_video.pix <= nbr_q.p01;
            default: out_video.pix <= nbr_q.p11;
        endcase
        if (!rst_n)
        begin
            out_video.vsync <= 1'b0;
            out_video.de    <= 1'b0;
        end
        else
        begin
            out_video.vsync <= vs_q[LAST];
            out_video.de    <= de_q[LAST];
        end
    end

endmodule

`default_nettype wire

/* design/nearest_scaler_top.sv */
// ----------------------------------------------------------
// nearest-neighbour RGB scaler, top level
// source stream in, scaled stream out, static configuration
// ----------------------------------------------------------
`default_nettype none
`include "scaler_defs.svh"

module nearest_scaler_top (
    input  logic                    clk_in2,
    input  logic                    rst_n,
    input  scaler_pkg::scaler_cfg_t cfg,
    input  scaler_pkg::video_t      in_video,
    output scaler_pkg::video_t      out_video
);

    import scaler_pkg::*;

    lb_wr_t                lb_wr;
    lb_rd_t                lb_rd;
    quad_t                 lb_quad;
    coord_t                coord;
    logic                  tag_push;
    logic [`SCL_DIM_W-1:0] tag_push_row;
    logic                  tag_pop;
    logic [`SCL_DIM_W-1:0] tag_head_row;
    logic                  tag_empty;

    row_writer i_row_writer (
        .clk_in2   (clk_in2),
        .rst_n     (rst_n),
        .in_video  (in_video),
        .src_width (cfg.src_width),
        .wr        (lb_wr),
        .tag_push  (tag_push),
        .tag_row   (tag_push_row)
    );

    row_tag_fifo i_row_tag_fifo (
        .clk_in2  (clk_in2),
        .rst_n    (rst_n),
        .push     (tag_push),
        .push_row (tag_push_row),
        .pop      (tag_pop),
        .head_row (tag_head_row),
        .empty    (tag_empty)
    );

    line_buffer i_line_buffer (
        .clk_in2 (clk_in2),
        .wr      (lb_wr),
        .rd      (lb_rd),
        .quad    (lb_quad)
    );

    scale_sequencer i_scale_sequencer (
        .clk_in2   (clk_in2),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .tag_empty (tag_empty),
        .tag_row   (tag_head_row),
        .tag_pop   (tag_pop),
        .coord     (coord)
    );

    sample_pipe i_sample_pipe (
        .clk_in2   (clk_in2),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .coord     (coord),
        .rd        (lb_rd),
        .quad      (lb_quad),
        .out_video (out_video)
    );

endmodule

`default_nettype wire

/* dv/tb_nearest_scaler.sv */
// ----------------------------------------------------------
// testbench of the nearest-neighbour scaler
// reads test frames and expected pixels from the vectors
// file, streams each frame in and checks every output pixel
// ----------------------------------------------------------
`default_nettype none
`include "scaler_defs.svh"

module tb_nearest_scaler;

    timeunit 1ns;
    timeprecision 1ps;

    import scaler_pkg::*;

    localparam int VEC_DEPTH    = 256;
    localparam int RESET_CYCLES = 10;
    localparam int QUIET_CYCLES = 20;    // idle watch before any input
    localparam int MAX_GAP      = 8;     // de low cycles after a row
    localparam int FRAME_GAP    = 20;

    logic        clk_in2;
    logic        rst_n;
    scaler_cfg_t cfg;
    video_t      in_video;
    video_t      out_video;

    logic [31:0] vec_mem [VEC_DEPTH];
    logic [23:0] exp_q [$];            // expected pixels in output order
    integer      seed;
    int          frame_pix;
    int          frames_done;          // falling edges of output vsync
    logic        vs_prev;
    logic        de_prev;
    int          cycle_cnt;
    int          cycle_limit;
    int          ptr;
    int          sw;
    int          sh;
    int          dw;
    int          dh;
    int          n_test;

    nearest_scaler_top i_nearest_scaler_top (
        .clk_in2   (clk_in2),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .in_video  (in_video),
        .out_video (out_video)
    );

    initial
    begin
        clk_in2 = 1'b0;
        forever
            #50 clk_in2 = ~clk_in2;
    end

    // ------------------------------------------------------
    // helpers
    // ------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("[ERROR] %0d ns %s expected %h actual %h",
                     $time, name, exp_val, act_val);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_in2);
        #5;
    endtask

    task automatic drive_frame(input int base, input int width, input int height);
        int gap;
        next_cycle();
        in_video.vsync = 1'b1;
        in_video.de    = 1'b0;
        for (int r = 0; r < height; r++)
        begin
            for (int c = 0; c < width; c++)
            begin
                next_cycle();
                in_video.de  = 1'b1;
                in_video.pix = vec_mem[base + r * width + c][23:0];
            end
            gap = 1 + ($unsigned($random(seed)) % MAX_GAP);
            repeat (gap)
            begin
                next_cycle();
                in_video.de = 1'b0;
            end
        end
        next_cycle();
        in_video.vsync = 1'b0;
    endtask

    // ------------------------------------------------------
    // output monitor and timeout
    // ------------------------------------------------------
    always @(negedge clk_in2)
    begin
        if (rst_n)
        begin
            if (out_video.de)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("output pixel at %0d ns with no pixel left to expect", $time);
                    $display("SIMULATION FAILED");
                    $fatal(1, "unexpected output pixel");
                end
                else
                begin
                    check_value("out_video.pix", {8'h00, exp_q[0]}, {8'h00, out_video.pix});
                    check_value("out_video.vsync", 32'd1, {31'd0, out_video.vsync});
                    exp_q.delete(0);
                    frame_pix++;
                end
            end
            // vsync rises with the first pixel
            if (out_video.vsync && !vs_prev)
                check_value("out_video.de", 32'd1, {31'd0, out_video.de});
            // and falls right after the last one
            if (!out_video.vsync && vs_prev)
            begin
                check_value("out_video.de before vsync fall", 32'd1, {31'd0, de_prev});
                frames_done++;
            end
            vs_prev = out_video.vsync;
            de_prev = out_video.de;
        end
    end

    always @(posedge clk_in2)
    begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit)
        begin
            $display("timeout: the run passed %0d cycles before all tests finished",
                     cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------
    // main sequence
    // ------------------------------------------------------
    initial
    begin
        seed        = 32'h7aca;
        frame_pix   = 0;
        frames_done = 0;
        vs_prev     = 1'b0;
        de_prev     = 1'b0;
        cycle_cnt   = 0;
        n_test      = 0;
        rst_n       = 1'b0;
        cfg         = '0;
        in_video    = '0;

        $readmemh("dv/scaler_vectors.hex", vec_mem);

        // limit from the length of all tests
        ptr         = 0;
        cycle_limit = 0;
        while (vec_mem[ptr] !== 32'h0)
        begin
            sw = vec_mem[ptr];
            sh = vec_mem[ptr+1];
            dw = vec_mem[ptr+2];
            dh = vec_mem[ptr+3];
            cycle_limit += sw * sh + sh * MAX_GAP + FRAME_GAP + dw * dh + `SCL_PIPE_LAT;
            ptr += 6 + sw * sh + dw * dh;
        end
        cycle_limit = 2 * cycle_limit + RESET_CYCLES + QUIET_CYCLES;

        repeat (RESET_CYCLES)
            @(posedge clk_in2);
        #5;
        rst_n = 1'b1;

        // nothing comes out before any input
        repeat (QUIET_CYCLES)
        begin
            @(negedge clk_in2);
            check_value("out_video.vsync", 32'd0, {31'd0, out_video.vsync});
            check_value("out_video.de", 32'd0, {31'd0, out_video.de});
        end

        ptr = 0;
        while (vec_mem[ptr] !== 32'h0)
        begin
            sw = vec_mem[ptr];
            sh = vec_mem[ptr+1];
            dw = vec_mem[ptr+2];
            dh = vec_mem[ptr+3];
            next_cycle();
            cfg.src_width  = sw[`SCL_DIM_W-1:0];
            cfg.src_height = sh[`SCL_DIM_W-1:0];
            cfg.dst_width  = dw[`SCL_DIM_W-1:0];
            cfg.dst_height = dh[`SCL_DIM_W-1:0];
            cfg.x_ratio    = vec_mem[ptr+4][`SCL_RATIO_W-1:0];
            cfg.y_ratio    = vec_mem[ptr+5][`SCL_RATIO_W-1:0];
            for (int i = 0; i < dw * dh; i++)
                exp_q.push_back(vec_mem[ptr + 6 + sw * sh + i][23:0]);
            frame_pix = 0;

            drive_frame(ptr + 6, sw, sh);
            // output frame ends when vsync falls
            while (frames_done <= n_test)
                @(negedge clk_in2);
            check_value("frame pixel count", dw * dh, frame_pix);

            repeat (FRAME_GAP)
                next_cycle();
            ptr += 6 + sw * sh + dw * dh;
            n_test++;
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/scaler_vectors.hex */
// per test: src_w src_h dst_w dst_h x_ratio y_ratio (ratio FFFF is about 1.0)
// then source pixels rrggbb row by row, then expected pixels row by row; 0 ends
// identity 4x3
4 3 4 3 FFFF FFFF
004080 014181 024282 034383
105090 115191 125292 135393
2060A0 2161A1 2262A2 2363A3
004080 014181 024282 034383
105090 115191 125292 135393
2060A0 2161A1 2262A2 2363A3
// upscale by 2, 3x2 to 6x4
3 2 6 4 8000 8000
004080 014181 024282
105090 115191 125292
004080 014181 014181 024282 024282 024282
105090 115191 115191 125292 125292 125292
105090 115191 115191 125292 125292 125292
105090 115191 115191 125292 125292 125292
// unequal ratios 0.75 and 0.625, 5x4 to 6x5
5 4 6 5 C000 A000
004080 014181 024282 034383 044484
105090 115191 125292 135393 145494
2060A0 2161A1 2262A2 2363A3 2464A4
3070B0 3171B1 3272B2 3373B3 3474B4
004080 014181 024282 024282 034383 044484
105090 115191 125292 125292 135393 145494
105090 115191 125292 125292 135393 145494
2060A0 2161A1 2262A2 2262A2 2363A3 2464A4
3070B0 3171B1 3272B2 3272B2 3373B3 3474B4
// edge clamp, 4x3 to 5x4
4 3 5 4 E000 C000
004080 014181 024282 034383
105090 115191 125292 135393
2060A0 2161A1 2262A2 2363A3
004080 014181 024282 034383 034383
105090 115191 125292 135393 135393
2060A0 2161A1 2262A2 2363A3 2363A3
2060A0 2161A1 2262A2 2363A3 2363A3
0

/* nearest_scaler_top.f */
+incdir+design
design/scaler_pkg.sv
design/row_writer.sv
design/row_tag_fifo.sv
design/line_buffer.sv
design/scale_sequencer.sv
design/sample_pipe.sv
design/nearest_scaler_top.sv
dv/tb_nearest_scaler.sv

/* Bender.yml */
package:
  name: nearest_scaler

sources:
  - include_dirs:
      - design
    files:
      - design/scaler_pkg.sv
      - design/row_writer.sv
      - design/row_tag_fifo.sv
      - design/line_buffer.sv
      - design/scale_sequencer.sv
      - design/sample_pipe.sv
      - design/nearest_scaler_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_nearest_scaler.sv
